// ==== flist.f ====
design/ladybird_pkg.sv
design/ladybird_crossbar.sv
design/ladybird_block_ram.sv
design/ladybird_gpio.sv
design/ladybird_uart_tx.sv
design/ladybird_soc.sv
test/ladybird_tb.sv

// ==== Bender.yml ====
package:
  name: ladybird

sources:
  - design/ladybird_pkg.sv
  - design/ladybird_crossbar.sv
  - design/ladybird_block_ram.sv
  - design/ladybird_gpio.sv
  - design/ladybird_uart_tx.sv
  - design/ladybird_soc.sv
  - target: test
    files:
      - test/ladybird_tb.sv

// ==== test/ladybird_tb.sv ====
`timescale 1ns/1ps

module ladybird_tb
  import ladybird_pkg::*;
();

  localparam int MAX_WAIT   = 1000;
  localparam int N_WORDS    = 8;
  localparam int BRAM_WORDS = 2**(BRAM_SIZE_W-2);

  logic       clk;
  logic       anrst;
  apb_req_t   mst_req [2]; // 0 ibus, 1 dbus
  apb_rsp_t   mst_rsp [2];
  logic [3:0] sw;
  logic [3:0] btn;
  logic [3:0] led;
  logic       irq;
  logic       uart_tx;

  int checks;
  int errors;
  bit frame_done;   // first uart frame fully sampled

  ladybird_soc DUT (
    .clk_i      (clk),
    .anrst_i    (anrst),
    .ibus_req_i (mst_req[0]),
    .ibus_rsp_o (mst_rsp[0]),
    .dbus_req_i (mst_req[1]),
    .dbus_rsp_o (mst_rsp[1]),
    .sw_i       (sw),
    .btn_i      (btn),
    .led_o      (led),
    .irq_o      (irq),
    .uart_tx_o  (uart_tx)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  ////////////////////////////////////////////////////////////
  // compare and run control
  ////////////////////////////////////////////////////////////

  task automatic check_data(input logic [XLEN-1:0] got, input logic [XLEN-1:0] exp,
                            input string msg);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Fail %0t: %s, got %h expected %h", $time, msg, got, exp);
    end
  endtask

  task automatic check_rsp(input apb_rsp_t rsp, input logic exp_err, input string msg);
    checks++;
    if (rsp.pslverr !== exp_err) begin
      errors++;
      $display("Fail %0t: %s, pslverr %b expected %b", $time, msg, rsp.pslverr, exp_err);
    end
  endtask

  task automatic check_bit(input logic got, input logic exp, input string msg);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Fail %0t: %s, got %b expected %b", $time, msg, got, exp);
    end
  endtask

  task automatic finish_run();
    $display("checks %0d errors %0d", checks, errors);
    if (errors == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  endtask

  task automatic report_timeout(input string what);
    errors++;
    $display("timeout at %0t: %s", $time, what);
    finish_run();
  endtask

  ////////////////////////////////////////////////////////////
  // apb master
  ////////////////////////////////////////////////////////////

  task automatic apb_transfer(input int m, input logic [XLEN-1:0] addr, input logic wr,
                              input logic [XLEN-1:0] wdata, input logic [3:0] strb,
                              output apb_rsp_t rsp);
    apb_req_t req;
    int       cycles;
    req        = '0;
    req.paddr  = addr;
    req.pwrite = wr;
    req.pwdata = wdata;
    req.pstrb  = strb;
    req.psel   = 1'b1;
    rsp        = '0;
    cycles     = 0;
    @(posedge clk);
    #2 mst_req[m] = req; // setup cycle
    @(posedge clk);
    req.penable = 1'b1;
    #2 mst_req[m] = req;
    while (!rsp.pready && cycles < MAX_WAIT) begin
      @(negedge clk);
      rsp = mst_rsp[m];
      cycles++;
    end
    if (!rsp.pready) begin
      report_timeout($sformatf("master %0d got no pready for address %h", m, addr));
    end else begin
      @(posedge clk);
      #2 mst_req[m] = '0;
    end
  endtask

  task automatic apb_write(input int m, input logic [XLEN-1:0] addr,
                           input logic [XLEN-1:0] data, input logic [3:0] strb,
                           output apb_rsp_t rsp);
    apb_transfer(m, addr, 1'b1, data, strb, rsp);
  endtask

  task automatic apb_read(input int m, input logic [XLEN-1:0] addr,
                          output logic [XLEN-1:0] data, output apb_rsp_t rsp);
    apb_transfer(m, addr, 1'b0, '0, 4'h0, rsp);
    data = rsp.prdata;
  endtask

  task automatic wait_irq(input logic level);
    int cycles;
    cycles = 0;
    while (irq !== level && cycles < MAX_WAIT) begin
      @(negedge clk);
      cycles++;
    end
    if (irq !== level) begin
      report_timeout($sformatf("irq_o never went to %b", level));
    end
  endtask

  // samples each bit in its middle, starting from the falling edge
  task automatic uart_capture(output logic [7:0] data);
    int cycles;
    cycles = 0;
    data   = '0;
    while (uart_tx !== 1'b0 && cycles < MAX_WAIT) begin
      @(negedge clk);
      cycles++;
    end
    if (uart_tx !== 1'b0) begin
      report_timeout("no start bit on uart_tx_o");
    end else begin
      repeat (CLKS_PER_BIT/2 - 1) @(negedge clk);
      check_bit(uart_tx, 1'b0, "uart start bit");
      for (int i = 0; i < 8; i++) begin
        repeat (CLKS_PER_BIT) @(negedge clk);
        data[i] = uart_tx; // lsb first
      end
      repeat (CLKS_PER_BIT) @(negedge clk);
      check_bit(uart_tx, 1'b1, "uart stop bit");
    end
  endtask

  ////////////////////////////////////////////////////////////
  // directed tests
  ////////////////////////////////////////////////////////////

  task automatic reset_outputs();
    @(negedge clk);
    check_data(XLEN'(led), '0, "led after reset");
    check_bit(irq, 1'b0, "irq after reset");
    check_bit(uart_tx, 1'b1, "uart line idle after reset");
    check_bit(mst_rsp[0].pready, 1'b0, "ibus pready after reset");
    check_bit(mst_rsp[1].pready, 1'b0, "dbus pready after reset");
  endtask

  task automatic bram_readback();
    logic [XLEN-1:0] model [BRAM_WORDS];
    int              idx   [N_WORDS];
    logic [XLEN-1:0] wdata;
    logic [XLEN-1:0] rdata;
    logic [3:0]      strb;
    apb_rsp_t        rsp;
    for (int i = 0; i < N_WORDS; i++) begin
      idx[i] = $urandom % BRAM_WORDS;
      wdata  = $urandom;
      apb_write(1, BRAM_BASE + XLEN'(idx[i] << 2), wdata, 4'hF, rsp);
      check_rsp(rsp, 1'b0, "bram full write");
      model[idx[i]] = wdata;
    end
    // byte strobes on every other word
    for (int i = 0; i < N_WORDS; i += 2) begin
      wdata = $urandom;
      strb  = 4'($urandom);
      apb_write(1, BRAM_BASE + XLEN'(idx[i] << 2), wdata, strb, rsp);
      for (int b = 0; b < XLEN/8; b++) begin
        if (strb[b]) model[idx[i]][8*b +: 8] = wdata[8*b +: 8];
      end
    end
    for (int i = 0; i < N_WORDS; i++) begin
      apb_read(0, BRAM_BASE + XLEN'(idx[i] << 2), rdata, rsp);
      check_data(rdata, model[idx[i]], $sformatf("bram word %0d", idx[i]));
    end
  endtask

  task automatic gpio_io();
    logic [XLEN-1:0] rdata;
    apb_rsp_t        rsp;
    @(posedge clk);
    #2;
    sw  = 4'hA;
    btn = 4'h5;
    repeat (4) @(posedge clk); // input synchronizer
    apb_read(1, GPIO_BASE + GPIO_IN, rdata, rsp);
    check_data(rdata, XLEN'({sw, btn}), "gpio input register");
    apb_write(1, GPIO_BASE + GPIO_OUT, 32'h9, 4'hF, rsp);
    @(negedge clk);
    check_data(XLEN'(led), 32'h9, "led output");
    apb_read(0, GPIO_BASE + GPIO_OUT, rdata, rsp);
    check_data(rdata, 32'h9, "gpio output readback");
  endtask

  task automatic gpio_interrupts();
    logic [7:0]      ie;
    logic [7:0]      prev_in;
    logic [7:0]      exp_pend;
    logic [XLEN-1:0] rdata;
    apb_rsp_t        rsp;
    ie = 8'h11; // sw[0] and btn[0]
    @(posedge clk);
    #2;
    sw  = '0;
    btn = '0;
    repeat (4) @(posedge clk);
    apb_write(1, GPIO_BASE + GPIO_IE, XLEN'(ie), 4'hF, rsp);
    @(posedge clk);
    #2 btn = 4'b0010;           // disabled input
    repeat (5) @(posedge clk);
    @(negedge clk);
    check_bit(irq, 1'b0, "irq from disabled input");
    apb_read(1, GPIO_BASE + GPIO_PEND, rdata, rsp);
    check_data(rdata, '0, "pending after disabled edge");
    prev_in = {sw, btn};
    @(posedge clk);
    #2;
    sw  = 4'b0001;
    btn = 4'b0011;
    exp_pend = {sw, btn} & ~prev_in & ie;
    wait_irq(1'b1);
    apb_read(0, GPIO_BASE + GPIO_PEND, rdata, rsp);
    check_data(rdata, XLEN'(exp_pend), "pending after enabled edges");
    apb_write(1, GPIO_BASE + GPIO_PEND, XLEN'(exp_pend), 4'hF, rsp);
    @(negedge clk);
    check_bit(irq, 1'b0, "irq after pending clear");
    apb_read(1, GPIO_BASE + GPIO_PEND, rdata, rsp);
    check_data(rdata, '0, "pending after clear");
  endtask

  task automatic uart_frame();
    logic [7:0]      byte0;
    logic [7:0]      byte1;
    logic [7:0]      got0;
    logic [7:0]      got1;
    logic [XLEN-1:0] rdata;
    apb_rsp_t        rsp;
    byte0      = 8'($urandom);
    byte1      = 8'($urandom);
    frame_done = 1'b0;
    fork
      begin
        uart_capture(got0);
        frame_done = 1'b1;
        uart_capture(got1);
      end
      begin
        apb_write(1, UART_BASE, XLEN'(byte0), 4'hF, rsp);
        apb_read(1, UART_BASE + 32'h4, rdata, rsp);
        check_data(rdata, 32'h1, "uart status busy during frame");
        apb_write(1, UART_BASE, XLEN'(byte1), 4'hF, rsp); // stalls
        check_bit(frame_done, 1'b1, "second uart write held until frame end");
      end
    join
    check_data(XLEN'(got0), XLEN'(byte0), "first uart byte");
    check_data(XLEN'(got1), XLEN'(byte1), "second uart byte");
  endtask

  task automatic unmapped_access();
    logic [XLEN-1:0] rdata;
    apb_rsp_t        rsp;
    apb_read(1, 32'h4000_0000, rdata, rsp);
    check_rsp(rsp, 1'b1, "unmapped read error");
    check_data(rdata, '0, "unmapped read data");
    apb_write(0, 32'h9000_2000, 32'hDEAD_BEEF, 4'hF, rsp); // just past bram
    check_rsp(rsp, 1'b1, "unmapped write error");
  endtask

  task automatic concurrent_masters();
    logic [XLEN-1:0] addr_w;
    logic [XLEN-1:0] addr_r;
    logic [XLEN-1:0] old_r;
    logic [XLEN-1:0] new_w;
    logic [XLEN-1:0] rdata;
    apb_rsp_t        rsp_w;
    apb_rsp_t        rsp_r;
    // roles swap between rounds
    for (int round = 0; round < 2; round++) begin
      addr_w = BRAM_BASE + XLEN'(32'h100 + 16 * round);
      addr_r = addr_w + 32'h40;
      old_r  = $urandom;
      new_w  = $urandom;
      apb_write(1, addr_r, old_r, 4'hF, rsp_w);
      fork
        apb_write(round, addr_w, new_w, 4'hF, rsp_w);
        apb_read(1 - round, addr_r, rdata, rsp_r);
      join
      check_rsp(rsp_w, 1'b0, "concurrent write response");
      check_rsp(rsp_r, 1'b0, "concurrent read response");
      check_data(rdata, old_r, "read beside concurrent write");
      apb_read(1 - round, addr_w, rdata, rsp_r);
      check_data(rdata, new_w, "word from concurrent write");
    end
  endtask

  initial begin
    checks     = 0;
    errors     = 0;
    frame_done = 1'b0;
    anrst      = 1'b0;
    sw         = '0;
    btn        = '0;
    mst_req[0] = '0;
    mst_req[1] = '0;
    void'($urandom(32'h6efa));
    repeat (4) @(posedge clk);
    #2 anrst = 1'b1;
    repeat (3) @(posedge clk); // reset synchronizer
    reset_outputs();
    bram_readback();
    gpio_io();
    gpio_interrupts();
    uart_frame();
    unmapped_access();
    concurrent_masters();
    finish_run();
  end

endmodule

// ==== design/ladybird_soc.sv ====
`timescale 1ns/1ps

module ladybird_soc
  import ladybird_pkg::*;
(
  input  logic       clk_i,
  input  logic       anrst_i,
  // instruction master
  input  apb_req_t   ibus_req_i,
  output apb_rsp_t   ibus_rsp_o,
  // data master
  input  apb_req_t   dbus_req_i,
  output apb_rsp_t   dbus_rsp_o,
  // board io
  input  logic [3:0] sw_i,
  input  logic [3:0] btn_i,
  output logic [3:0] led_o,
  output logic       irq_o,
  output logic       uart_tx_o
);

  logic [1:0] rst_sync_q;
  logic       nrst;

  apb_req_t mst_req [2]; // 0 ibus, 1 dbus
  apb_rsp_t mst_rsp [2];
  apb_req_t slv_req [N_PERIPH];
  apb_rsp_t slv_rsp [N_PERIPH];

  ////////////////////////////////////////////////////////////
  // reset synchronizer
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i, negedge anrst_i) begin
    if (!anrst_i) begin
      rst_sync_q <= '0;
    end else begin
      rst_sync_q <= {rst_sync_q[0], 1'b1};
    end
  end

  assign nrst = rst_sync_q[1];

  assign mst_req[0] = ibus_req_i;
  assign mst_req[1] = dbus_req_i;
  assign ibus_rsp_o = mst_rsp[0];
  assign dbus_rsp_o = mst_rsp[1];

  ////////////////////////////////////////////////////////////
  // bus and peripherals
  ////////////////////////////////////////////////////////////

  ladybird_crossbar crossbar_inst (
    .clk_i     (clk_i),
    .anrst_i   (anrst_i),
    .nrst_i    (nrst),
    .mst_req_i (mst_req),
    .mst_rsp_o (mst_rsp),
    .slv_req_o (slv_req),
    .slv_rsp_i (slv_rsp)
  );

  ladybird_block_ram #(.ADDR_W(11)) bram_inst (
    .clk_i   (clk_i),
    .anrst_i (anrst_i),
    .nrst_i  (nrst),
    .req_i   (slv_req[PERIPH_BRAM]),
    .rsp_o   (slv_rsp[PERIPH_BRAM])
  );

  ladybird_gpio gpio_inst (
    .clk_i   (clk_i),
    .anrst_i (anrst_i),
    .nrst_i  (nrst),
    .req_i   (slv_req[PERIPH_GPIO]),
    .rsp_o   (slv_rsp[PERIPH_GPIO]),
    .gpio_i  ({sw_i, btn_i}), // switches in the upper nibble
    .gpio_o  (led_o),
    .irq_o   (irq_o)
  );

  ladybird_uart_tx uart_tx_inst (
    .clk_i   (clk_i),
    .anrst_i (anrst_i),
    .nrst_i  (nrst),
    .req_i   (slv_req[PERIPH_UART]),
    .rsp_o   (slv_rsp[PERIPH_UART]),
    .tx_o    (uart_tx_o)
  );

endmodule

// ==== design/ladybird_uart_tx.sv ====
`timescale 1ns/1ps

module ladybird_uart_tx
  import ladybird_pkg::*;
(
  input  logic     clk_i,
  input  logic     anrst_i,
  input  logic     nrst_i,
  input  apb_req_t req_i,
  output apb_rsp_t rsp_o,
  output logic     tx_o
);

  uart_state_e      state_q;
  logic [DIV_W-1:0] div_q;
  logic [2:0]       bit_q;
  logic [7:0]       shift_q;
  logic             tx_q;
  logic             busy;
  logic             bit_end;
  logic             is_data;  // offset 0x0, else status
  logic             access;
  logic             start;

  assign busy    = (state_q != TX_IDLE);
  assign bit_end = (div_q == DIV_W'(CLKS_PER_BIT - 1));
  assign is_data = (req_i.paddr[3:2] == 2'd0);
  assign access  = req_i.psel && req_i.penable;
  assign start   = access && req_i.pwrite && is_data && !busy;

  ////////////////////////////////////////////////////////////
  // frame FSM
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i, negedge anrst_i) begin
    if (!anrst_i) begin
      state_q <= TX_IDLE;
      div_q   <= '0;
      bit_q   <= '0;
      tx_q    <= 1'b1;
    end else if (!nrst_i) begin
      state_q <= TX_IDLE;
      div_q   <= '0;
      bit_q   <= '0;
      tx_q    <= 1'b1;
    end else begin
      div_q <= (state_q == TX_IDLE || bit_end) ? '0 : div_q + 1'b1;
      case (state_q)
        TX_IDLE: begin
          if (start) begin
            state_q <= TX_START;
            tx_q    <= 1'b0; // start bit
          end
        end
        TX_START: begin
          if (bit_end) begin
            state_q <= TX_DATA;
            bit_q   <= '0;
            tx_q    <= shift_q[0];
          end
        end
        TX_DATA: begin
          if (bit_end) begin
            bit_q <= bit_q + 1'b1;
            if (bit_q == 3'd7) begin
              state_q <= TX_STOP;
              tx_q    <= 1'b1;
            end else begin
              tx_q <= shift_q[1]; // next lsb
            end
          end
        end
        TX_STOP: begin
          if (bit_end) begin
            state_q <= TX_IDLE;
          end
        end
        default: state_q <= TX_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (start) begin
      shift_q <= req_i.pwdata[7:0];
    end else if (state_q == TX_DATA && bit_end) begin
      shift_q <= shift_q >> 1;
    end
  end

  // data writes stall while a frame is on the line
  assign rsp_o.pready  = access && !(is_data && req_i.pwrite && busy);
  assign rsp_o.prdata  = is_data ? '0 : XLEN'(busy);
  assign rsp_o.pslverr = 1'b0;
  assign tx_o          = tx_q;

  a_idle_high: assert property (@(posedge clk_i) disable iff (!anrst_i || !nrst_i)
    (state_q == TX_IDLE) |-> tx_o);

endmodule

// ==== design/ladybird_gpio.sv ====
`timescale 1ns/1ps

module ladybird_gpio
  import ladybird_pkg::*;
(
  input  logic       clk_i,
  input  logic       anrst_i,
  input  logic       nrst_i,
  input  apb_req_t   req_i,
  output apb_rsp_t   rsp_o,
  input  logic [7:0] gpio_i,
  output logic [3:0] gpio_o,
  output logic       irq_o
);

  logic [7:0] sync1_q;
  logic [7:0] sync2_q;
  logic [7:0] prev_q;   // for edge detect
  logic [3:0] out_q;
  logic [7:0] ie_q;
  logic [7:0] pend_q;
  logic [7:0] rise;
  logic [7:0] clr;
  logic       access;
  logic       wr_en;
  gpio_reg_e  reg_sel;

  assign reg_sel = gpio_reg_e'(req_i.paddr[3:0]);
  assign access  = req_i.psel && req_i.penable;
  assign wr_en   = access && req_i.pwrite;

  assign rise = sync2_q & ~prev_q;
  assign clr  = (wr_en && reg_sel == GPIO_PEND) ? req_i.pwdata[7:0] : '0; // write one to clear

  ////////////////////////////////////////////////////////////
  // registers
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i, negedge anrst_i) begin
    if (!anrst_i) begin
      sync1_q <= '0;
      sync2_q <= '0;
      prev_q  <= '0;
      out_q   <= '0;
      ie_q    <= '0;
      pend_q  <= '0;
    end else if (!nrst_i) begin
      sync1_q <= '0;
      sync2_q <= '0;
      prev_q  <= '0;
      out_q   <= '0;
      ie_q    <= '0;
      pend_q  <= '0;
    end else begin
      sync1_q <= gpio_i;
      sync2_q <= sync1_q;
      prev_q  <= sync2_q;
      if (wr_en && reg_sel == GPIO_OUT) begin
        out_q <= req_i.pwdata[3:0];
      end
      if (wr_en && reg_sel == GPIO_IE) begin
        ie_q <= req_i.pwdata[7:0];
      end
      pend_q <= (pend_q & ~clr) | (rise & ie_q); // new edge beats clear
    end
  end

  always_comb begin
    rsp_o        = '0;
    rsp_o.pready = access;
    case (reg_sel)
      GPIO_IN:   rsp_o.prdata = XLEN'(sync2_q);
      GPIO_OUT:  rsp_o.prdata = XLEN'(out_q);
      GPIO_IE:   rsp_o.prdata = XLEN'(ie_q);
      GPIO_PEND: rsp_o.prdata = XLEN'(pend_q);
      default:   rsp_o.pslverr = access; // unknown offset
    endcase
  end

  assign gpio_o = out_q;
  assign irq_o  = |pend_q;

endmodule

// ==== design/ladybird_block_ram.sv ====
`timescale 1ns/1ps

module ladybird_block_ram
  import ladybird_pkg::*;
#(
  parameter int ADDR_W = 11
) (
  input  logic     clk_i,
  input  logic     anrst_i,
  input  logic     nrst_i,
  input  apb_req_t req_i,
  output apb_rsp_t rsp_o
);

  logic [XLEN-1:0]   mem [2**ADDR_W];
  logic [ADDR_W-1:0] word_addr;
  logic [XLEN-1:0]   rdata_q;
  logic              lat_q;   // set in the second read access cycle
  logic              access;
  logic              wr_en;
  logic              rd_done;

  assign word_addr = req_i.paddr[ADDR_W+1:2];
  assign access    = req_i.psel && req_i.penable;
  assign wr_en     = access && req_i.pwrite;
  assign rd_done   = access && !req_i.pwrite && lat_q;

  always_ff @(posedge clk_i) begin
    if (wr_en) begin
      for (int b = 0; b < XLEN/8; b++) begin
        if (req_i.pstrb[b]) begin
          mem[word_addr][8*b +: 8] <= req_i.pwdata[8*b +: 8];
        end
      end
    end
    if (req_i.psel && !req_i.pwrite) begin
      rdata_q <= mem[word_addr]; // read register stage
    end
  end

  always_ff @(posedge clk_i, negedge anrst_i) begin
    if (!anrst_i) begin
      lat_q <= 1'b0;
    end else if (!nrst_i) begin
      lat_q <= 1'b0;
    end else begin
      lat_q <= access && !req_i.pwrite && !lat_q;
    end
  end

  assign rsp_o.prdata  = rdata_q;
  assign rsp_o.pready  = wr_en || rd_done;
  assign rsp_o.pslverr = 1'b0;

  a_penable_psel: assert property (@(posedge clk_i) disable iff (!anrst_i || !nrst_i)
    req_i.penable |-> req_i.psel);

endmodule

// ==== design/ladybird_crossbar.sv ====
`timescale 1ns/1ps

module ladybird_crossbar
  import ladybird_pkg::*;
(
  input  logic     clk_i,
  input  logic     anrst_i,
  input  logic     nrst_i,
  input  apb_req_t mst_req_i [2],
  output apb_rsp_t mst_rsp_o [2],
  output apb_req_t slv_req_o [N_PERIPH],
  input  apb_rsp_t slv_rsp_i [N_PERIPH]
);

  typedef enum logic [1:0] {
    XB_IDLE,
    XB_SETUP,
    XB_ACCESS
  } xb_state_e;

  xb_state_e           state_q;
  logic                grant_q;  // granted master
  logic                rr_q;     // preferred master on a tie
  periph_e             sel_q;
  logic [1:0]          req;
  logic                win;
  apb_rsp_t            sel_rsp;
  logic                done;
  logic [N_PERIPH-1:0] psel_vec;

  function automatic periph_e decode(input logic [XLEN-1:0] addr);
    periph_e sel;
    sel = PERIPH_NONE;
    if (addr[XLEN-1:BRAM_SIZE_W] == BRAM_BASE[XLEN-1:BRAM_SIZE_W])
      sel = PERIPH_BRAM;
    else if (addr[XLEN-1:REG_SIZE_W] == GPIO_BASE[XLEN-1:REG_SIZE_W])
      sel = PERIPH_GPIO;
    else if (addr[XLEN-1:REG_SIZE_W] == UART_BASE[XLEN-1:REG_SIZE_W])
      sel = PERIPH_UART;
    return sel;
  endfunction

  ////////////////////////////////////////////////////////////
  // arbitration
  ////////////////////////////////////////////////////////////

  assign req = {mst_req_i[1].psel, mst_req_i[0].psel};
  assign win = (req == 2'b11) ? rr_q : req[1];

  always_ff @(posedge clk_i, negedge anrst_i) begin
    if (!anrst_i) begin
      state_q <= XB_IDLE;
      grant_q <= 1'b0;
      rr_q    <= 1'b0;
      sel_q   <= PERIPH_NONE;
    end else if (!nrst_i) begin
      state_q <= XB_IDLE;
      grant_q <= 1'b0;
      rr_q    <= 1'b0;
      sel_q   <= PERIPH_NONE;
    end else begin
      case (state_q)
        XB_IDLE: begin
          if (|req) begin
            grant_q <= win;
            sel_q   <= decode(mst_req_i[win].paddr); // select registered with grant
            state_q <= XB_SETUP;
          end
        end
        XB_SETUP: state_q <= XB_ACCESS;
        XB_ACCESS: begin
          if (done) begin
            state_q <= XB_IDLE;
            rr_q    <= ~grant_q; // other master wins next tie
          end
        end
        default: state_q <= XB_IDLE;
      endcase
    end
  end

  ////////////////////////////////////////////////////////////
  // forwarding and response
  ////////////////////////////////////////////////////////////

  always_comb begin
    for (int p = 0; p < N_PERIPH; p++) begin
      slv_req_o[p]         = mst_req_i[grant_q];
      slv_req_o[p].psel    = (state_q != XB_IDLE) && (sel_q == periph_e'(p));
      slv_req_o[p].penable = (state_q == XB_ACCESS) && (sel_q == periph_e'(p));
      psel_vec[p]          = slv_req_o[p].psel;
    end
  end

  always_comb begin
    sel_rsp = '0;
    case (sel_q)
      PERIPH_BRAM: sel_rsp = slv_rsp_i[PERIPH_BRAM];
      PERIPH_GPIO: sel_rsp = slv_rsp_i[PERIPH_GPIO];
      PERIPH_UART: sel_rsp = slv_rsp_i[PERIPH_UART];
      default: begin
        // unmapped, answer with an error
        sel_rsp.pready  = 1'b1;
        sel_rsp.pslverr = 1'b1;
      end
    endcase
  end

  assign done = (state_q == XB_ACCESS) && sel_rsp.pready;

  // waiting master sees pready low
  for (genvar m = 0; m < 2; m++) begin : g_mst_rsp
    assign mst_rsp_o[m] = (state_q == XB_ACCESS && grant_q == 1'(m)) ? sel_rsp : '0;
  end

  a_one_psel: assert property (@(posedge clk_i) disable iff (!anrst_i || !nrst_i)
    $onehot0(psel_vec));

  a_req_stable: assert property (@(posedge clk_i) disable iff (!anrst_i || !nrst_i)
    (state_q != XB_IDLE && !mst_rsp_o[grant_q].pready) |=> $stable(mst_req_i[grant_q]));

endmodule

// ==== design/ladybird_pkg.sv ====
package ladybird_pkg;

  ////////////////////////////////////////////////////////////
  // bus
  ////////////////////////////////////////////////////////////

  localparam int XLEN = 32;

  typedef struct packed {
    logic [XLEN-1:0]   paddr;
    logic              pwrite;
    logic [XLEN-1:0]   pwdata;
    logic [XLEN/8-1:0] pstrb;   // byte lanes
    logic              psel;
    logic              penable;
  } apb_req_t;

  typedef struct packed {
    logic [XLEN-1:0] prdata;
    logic            pready;
    logic            pslverr;
  } apb_rsp_t;

  ////////////////////////////////////////////////////////////
  // address map
  ////////////////////////////////////////////////////////////

  localparam int N_PERIPH = 3;

  localparam logic [XLEN-1:0] BRAM_BASE = 32'h9000_0000;
  localparam logic [XLEN-1:0] GPIO_BASE = 32'h8000_0000;
  localparam logic [XLEN-1:0] UART_BASE = 32'h8000_1000;

  localparam int BRAM_SIZE_W = 13; // 8 KB window
  localparam int REG_SIZE_W  = 12; // 4 KB register window

  // doubles as slave port index, NONE has no port
  typedef enum logic [1:0] {
    PERIPH_BRAM,
    PERIPH_GPIO,
    PERIPH_UART,
    PERIPH_NONE
  } periph_e;

  typedef enum logic [3:0] {
    GPIO_IN   = 4'h0,
    GPIO_OUT  = 4'h4,
    GPIO_IE   = 4'h8,
    GPIO_PEND = 4'hC
  } gpio_reg_e;

  ////////////////////////////////////////////////////////////
  // uart
  ////////////////////////////////////////////////////////////

  typedef enum logic [1:0] {
    TX_IDLE,
    TX_START,
    TX_DATA,
    TX_STOP
  } uart_state_e;

  localparam int CLKS_PER_BIT = 16;
  localparam int DIV_W        = $clog2(CLKS_PER_BIT);

endpackage
